// ==== hw/previewer_pkg.sv ====
package previewer_pkg;

    ////////////////////
    // data widths

    // one grayscale pixel, also the width of a host byte
    typedef logic [7:0] pixel_t;

    // raw row or column index
    typedef logic [15:0] coord_t;

    // host command fields
    typedef logic [15:0] cmd_addr_t;
    typedef logic [31:0] cmd_data_t;

    // two address bytes plus four data bytes
    localparam int CMD_BYTES = 6;

    ////////////////////
    // frame header

    // "BIVFRAME", sent msb first
    localparam logic [63:0] MAGIC_NUM = 64'h42_49_56_46_52_41_4D_45;
    localparam int MAGIC_BYTES = 8;

    ////////////////////
    // command map

    localparam cmd_addr_t ADDR_ROI_COL = 16'd0;
    localparam cmd_addr_t ADDR_ROI_ROW = 16'd1;

    // output sequencer states
    typedef enum logic [1:0] {
        IDLE,
        HEADER,
        PIXELS
    } seq_state_t;

endpackage

// ==== hw/command_assembler.sv ====
`timescale 1ns/1ps

module command_assembler #(
    parameter int RAW_WIDTH = 16,
    parameter int ROI_WIDTH = 8
) (
    input  logic                   core_clk,
    input  logic                   sys_reset,
    input  previewer_pkg::pixel_t  cmd_byte_i,
    input  logic                   cmd_valid_i,
    output previewer_pkg::coord_t  roi_col_o,
    output previewer_pkg::coord_t  roi_row_o
);

    // centered horizontally, top aligned
    localparam previewer_pkg::coord_t DEFAULT_COL =
        previewer_pkg::coord_t'((RAW_WIDTH - ROI_WIDTH) / 2);
    localparam previewer_pkg::coord_t DEFAULT_ROW = '0;

    // first five bytes of the command, oldest in the top byte
    logic [39:0] byte_shift_q;
    logic [2:0]  byte_cnt_q;

    logic [47:0]              cmd_word;
    previewer_pkg::cmd_addr_t cmd_addr;
    previewer_pkg::cmd_data_t cmd_data;
    logic                     cmd_done;

    // the sixth byte completes the word in the same cycle
    assign cmd_word = {byte_shift_q, cmd_byte_i};
    assign cmd_addr = cmd_word[47:32];
    assign cmd_data = cmd_word[31:0];
    assign cmd_done = cmd_valid_i && (byte_cnt_q == 3'(previewer_pkg::CMD_BYTES - 1));

    always_ff @(posedge core_clk) begin
        if (cmd_valid_i) begin
            byte_shift_q <= {byte_shift_q[31:0], cmd_byte_i};
        end
    end

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            byte_cnt_q <= '0;
            roi_col_o  <= DEFAULT_COL;
            roi_row_o  <= DEFAULT_ROW;
        end else if (cmd_valid_i) begin
            byte_cnt_q <= cmd_done ? 3'd0 : byte_cnt_q + 3'd1;
            // corner registers take the low half of the data word
            if (cmd_done && cmd_addr == previewer_pkg::ADDR_ROI_COL) begin
                roi_col_o <= cmd_data[15:0];
            end
            if (cmd_done && cmd_addr == previewer_pkg::ADDR_ROI_ROW) begin
                roi_row_o <= cmd_data[15:0];
            end
        end
    end

endmodule

// ==== hw/roi_cropper.sv ====
`timescale 1ns/1ps

module roi_cropper #(
    parameter int RAW_WIDTH  = 16,
    parameter int ROI_WIDTH  = 8,
    parameter int ROI_HEIGHT = 6
) (
    input  logic                   core_clk,
    input  logic                   sys_reset,
    input  previewer_pkg::pixel_t  pix_data_i,
    input  logic                   pix_valid_i,
    input  logic                   pix_sof_i,
    input  previewer_pkg::coord_t  roi_col_i,
    input  previewer_pkg::coord_t  roi_row_i,
    output previewer_pkg::pixel_t  crop_data_o,
    output logic                   crop_valid_o,
    output logic                   crop_last_o
);

    localparam previewer_pkg::coord_t RAW_COL_LAST = previewer_pkg::coord_t'(RAW_WIDTH - 1);
    localparam previewer_pkg::coord_t ROI_W = previewer_pkg::coord_t'(ROI_WIDTH);
    localparam previewer_pkg::coord_t ROI_H = previewer_pkg::coord_t'(ROI_HEIGHT);

    // position of the next raw pixel
    previewer_pkg::coord_t col_q;
    previewer_pkg::coord_t row_q;

    // corner held for the whole frame
    previewer_pkg::coord_t corner_col_q;
    previewer_pkg::coord_t corner_row_q;

    previewer_pkg::coord_t cur_col;
    previewer_pkg::coord_t cur_row;
    previewer_pkg::coord_t cur_corner_col;
    previewer_pkg::coord_t cur_corner_row;
    previewer_pkg::coord_t col_off;
    previewer_pkg::coord_t row_off;
    logic                  in_roi;
    logic                  at_last;

    ////////////////////
    // current pixel position

    // sof pixel is always at the origin and uses the fresh corner
    assign cur_col        = pix_sof_i ? '0 : col_q;
    assign cur_row        = pix_sof_i ? '0 : row_q;
    assign cur_corner_col = pix_sof_i ? roi_col_i : corner_col_q;
    assign cur_corner_row = pix_sof_i ? roi_row_i : corner_row_q;

    // unsigned offsets wrap high when left of or above the corner
    assign col_off = cur_col - cur_corner_col;
    assign row_off = cur_row - cur_corner_row;
    assign in_roi  = (col_off < ROI_W) && (row_off < ROI_H);
    assign at_last = (col_off == ROI_W - 16'd1) && (row_off == ROI_H - 16'd1);

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            col_q        <= '0;
            row_q        <= '0;
            corner_col_q <= '0;
            corner_row_q <= '0;
        end else if (pix_valid_i) begin
            if (pix_sof_i) begin
                corner_col_q <= roi_col_i;
                corner_row_q <= roi_row_i;
            end
            if (cur_col == RAW_COL_LAST) begin
                col_q <= '0;
                row_q <= cur_row + 16'd1;
            end else begin
                col_q <= cur_col + 16'd1;
                row_q <= cur_row;
            end
        end
    end

    ////////////////////
    // output register

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            crop_valid_o <= 1'b0;
            crop_last_o  <= 1'b0;
        end else begin
            crop_valid_o <= pix_valid_i && in_roi;
            crop_last_o  <= pix_valid_i && in_roi && at_last;
        end
    end

    always_ff @(posedge core_clk) begin
        crop_data_o <= pix_data_i;
    end

endmodule

// ==== hw/frame_fifo.sv ====
`timescale 1ns/1ps

module frame_fifo #(
    parameter int FIFO_DEPTH = 64
) (
    input  logic                   core_clk,
    input  logic                   sys_reset,
    input  previewer_pkg::pixel_t  wr_data_i,
    input  logic                   wr_valid_i,
    input  logic                   wr_last_i,
    input  logic                   pop_i,
    output previewer_pkg::pixel_t  rd_data_o,
    output logic                   rd_last_o,
    output logic                   empty_o
);

    localparam int AW = $clog2(FIFO_DEPTH);

    // storage, pixel and end-of-frame flag side by side
    previewer_pkg::pixel_t data_mem [FIFO_DEPTH];
    logic                  last_mem [FIFO_DEPTH];

    // extra msb tells full from empty
    logic [AW:0] wr_ptr_q;
    logic [AW:0] rd_ptr_q;

    logic full;
    logic do_write;
    logic do_read;

    assign empty_o  = (wr_ptr_q == rd_ptr_q);
    assign full     = (wr_ptr_q[AW] != rd_ptr_q[AW]) &&
                      (wr_ptr_q[AW-1:0] == rd_ptr_q[AW-1:0]);
    assign do_write = wr_valid_i && !full;
    assign do_read  = pop_i && !empty_o;

    // head entry shown without a read cycle
    assign rd_data_o = data_mem[rd_ptr_q[AW-1:0]];
    assign rd_last_o = last_mem[rd_ptr_q[AW-1:0]];

    always_ff @(posedge core_clk) begin
        if (do_write) begin
            data_mem[wr_ptr_q[AW-1:0]] <= wr_data_i;
            last_mem[wr_ptr_q[AW-1:0]] <= wr_last_i;
        end
    end

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (do_write) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_read) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
        end
    end

endmodule

// ==== hw/frame_sequencer.sv ====
`timescale 1ns/1ps

module frame_sequencer (
    input  logic                   core_clk,
    input  logic                   sys_reset,
    input  logic                   fifo_empty_i,
    input  logic                   fifo_last_i,
    input  previewer_pkg::pixel_t  fifo_data_i,
    input  logic                   host_ready_i,
    output logic                   fifo_pop_o,
    output previewer_pkg::pixel_t  tx_data_o,
    output logic                   tx_valid_o
);

    localparam int IDX_W = $clog2(previewer_pkg::MAGIC_BYTES);
    localparam logic [IDX_W-1:0] HDR_LAST = IDX_W'(previewer_pkg::MAGIC_BYTES - 1);

    previewer_pkg::seq_state_t state_q;
    logic [IDX_W-1:0]          hdr_idx_q;

    previewer_pkg::pixel_t hdr_byte;
    logic                  hdr_send;

    // msb first, so index 0 picks the top byte
    assign hdr_byte = previewer_pkg::MAGIC_NUM[(HDR_LAST - hdr_idx_q) * 8 +: 8];

    assign hdr_send   = (state_q == previewer_pkg::HEADER) && host_ready_i;
    assign fifo_pop_o = (state_q == previewer_pkg::PIXELS) && host_ready_i && !fifo_empty_i;

    ////////////////////
    // state machine

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            state_q   <= previewer_pkg::IDLE;
            hdr_idx_q <= '0;
        end else begin
            case (state_q)
                previewer_pkg::IDLE: begin
                    hdr_idx_q <= '0;
                    // any buffered pixel means a frame has started
                    if (!fifo_empty_i) begin
                        state_q <= previewer_pkg::HEADER;
                    end
                end
                previewer_pkg::HEADER: begin
                    if (hdr_send) begin
                        hdr_idx_q <= hdr_idx_q + 1'b1;
                        if (hdr_idx_q == HDR_LAST) begin
                            state_q <= previewer_pkg::PIXELS;
                        end
                    end
                end
                previewer_pkg::PIXELS: begin
                    if (fifo_pop_o && fifo_last_i) begin
                        state_q <= previewer_pkg::IDLE;
                    end
                end
                default: begin
                    state_q <= previewer_pkg::IDLE;
                end
            endcase
        end
    end

    ////////////////////
    // byte output

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            tx_valid_o <= 1'b0;
        end else begin
            tx_valid_o <= hdr_send || fifo_pop_o;
        end
    end

    always_ff @(posedge core_clk) begin
        if (hdr_send) begin
            tx_data_o <= hdr_byte;
        end else if (fifo_pop_o) begin
            tx_data_o <= fifo_data_i;
        end
    end

endmodule

// ==== hw/previewer_top.sv ====
`timescale 1ns/1ps

module previewer_top #(
    // raw frame from the input stream
    parameter int RAW_WIDTH  = 16,
    parameter int RAW_HEIGHT = 12,

    // window sent to the host
    parameter int ROI_WIDTH  = 8,
    parameter int ROI_HEIGHT = 6,

    // must hold a full roi frame
    parameter int FIFO_DEPTH = 64
) (
    input  logic                   core_clk,
    input  logic                   sys_reset,

    input  previewer_pkg::pixel_t  cmd_byte_i,
    input  logic                   cmd_valid_i,

    input  previewer_pkg::pixel_t  pix_data_i,
    input  logic                   pix_valid_i,
    input  logic                   pix_sof_i,

    input  logic                   host_ready_i,
    output previewer_pkg::pixel_t  tx_data_o,
    output logic                   tx_valid_o
);

    previewer_pkg::coord_t roi_col;
    previewer_pkg::coord_t roi_row;

    previewer_pkg::pixel_t crop_data;
    logic                  crop_valid;
    logic                  crop_last;

    previewer_pkg::pixel_t rd_data;
    logic                  rd_last;
    logic                  fifo_empty;
    logic                  fifo_pop;

    ////////////////////
    // host commands

    command_assembler #(
        .RAW_WIDTH (RAW_WIDTH),
        .ROI_WIDTH (ROI_WIDTH)
    ) u_command_assembler (
        .core_clk    (core_clk),
        .sys_reset   (sys_reset),
        .cmd_byte_i  (cmd_byte_i),
        .cmd_valid_i (cmd_valid_i),
        .roi_col_o   (roi_col),
        .roi_row_o   (roi_row)
    );

    ////////////////////
    // crop and buffer

    // raw height only bounds legal corners, the cropper restarts on sof
    roi_cropper #(
        .RAW_WIDTH  (RAW_WIDTH),
        .ROI_WIDTH  (ROI_WIDTH),
        .ROI_HEIGHT (ROI_HEIGHT)
    ) u_roi_cropper (
        .core_clk     (core_clk),
        .sys_reset    (sys_reset),
        .pix_data_i   (pix_data_i),
        .pix_valid_i  (pix_valid_i),
        .pix_sof_i    (pix_sof_i),
        .roi_col_i    (roi_col),
        .roi_row_i    (roi_row),
        .crop_data_o  (crop_data),
        .crop_valid_o (crop_valid),
        .crop_last_o  (crop_last)
    );

    frame_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_frame_fifo (
        .core_clk   (core_clk),
        .sys_reset  (sys_reset),
        .wr_data_i  (crop_data),
        .wr_valid_i (crop_valid),
        .wr_last_i  (crop_last),
        .pop_i      (fifo_pop),
        .rd_data_o  (rd_data),
        .rd_last_o  (rd_last),
        .empty_o    (fifo_empty)
    );

    ////////////////////
    // host byte stream

    frame_sequencer u_frame_sequencer (
        .core_clk     (core_clk),
        .sys_reset    (sys_reset),
        .fifo_empty_i (fifo_empty),
        .fifo_last_i  (rd_last),
        .fifo_data_i  (rd_data),
        .host_ready_i (host_ready_i),
        .fifo_pop_o   (fifo_pop),
        .tx_data_o    (tx_data_o),
        .tx_valid_o   (tx_valid_o)
    );

endmodule

// ==== dv/previewer_tb.sv ====
`timescale 1ns/1ps

module previewer_tb;

    localparam int RAW_WIDTH   = 16;
    localparam int RAW_HEIGHT  = 12;
    localparam int ROI_WIDTH   = 8;
    localparam int ROI_HEIGHT  = 6;
    localparam int FIFO_DEPTH  = 64;
    localparam int RAW_PIXELS  = RAW_WIDTH * RAW_HEIGHT;
    localparam int FRAME_BYTES = previewer_pkg::MAGIC_BYTES + ROI_WIDTH * ROI_HEIGHT;
    localparam int WAIT_LIMIT  = 4000;

    // frame header text, first character in the top byte
    localparam logic [63:0] MAGIC_TEXT = "BIVFRAME";

    logic                  core_clk;
    logic                  sys_reset;
    previewer_pkg::pixel_t cmd_byte;
    logic                  cmd_valid;
    previewer_pkg::pixel_t pix_data;
    logic                  pix_valid;
    logic                  pix_sof;
    logic                  host_ready;
    previewer_pkg::pixel_t tx_data;
    logic                  tx_valid;

    integer seed;
    int     errors;
    int     tests_run;
    int     tests_failed;
    bit     rand_ready;

    // reference corner, as the host last wrote it
    int corner_col;
    int corner_row;

    previewer_pkg::pixel_t raw_frame [RAW_PIXELS];
    previewer_pkg::pixel_t exp_q [$];
    previewer_pkg::pixel_t got_q [$];

    previewer_top #(
        .RAW_WIDTH  (RAW_WIDTH),
        .RAW_HEIGHT (RAW_HEIGHT),
        .ROI_WIDTH  (ROI_WIDTH),
        .ROI_HEIGHT (ROI_HEIGHT),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) DUT (
        .core_clk     (core_clk),
        .sys_reset    (sys_reset),
        .cmd_byte_i   (cmd_byte),
        .cmd_valid_i  (cmd_valid),
        .pix_data_i   (pix_data),
        .pix_valid_i  (pix_valid),
        .pix_sof_i    (pix_sof),
        .host_ready_i (host_ready),
        .tx_data_o    (tx_data),
        .tx_valid_o   (tx_valid)
    );

    always #4 core_clk = ~core_clk;

    // outputs only move on the rising edge
    always @(negedge core_clk) begin
        if (!sys_reset && tx_valid) begin
            got_q.push_back(tx_data);
        end
    end

    ////////////////////
    // helpers

    function automatic int rand_below(int n);
        return ($random(seed) & 32'h7fff_ffff) % n;
    endfunction

    // next falling edge, host ready redrawn when randomized
    task automatic step();
        @(negedge core_clk);
        if (rand_ready) begin
            host_ready = rand_below(2);
        end
    endtask

    task automatic check_val(string name, logic [31:0] expected, logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("ERR %s expected %0h actual %0h", name, expected, actual);
        end
    endtask

    task automatic send_cmd(previewer_pkg::cmd_addr_t addr, previewer_pkg::cmd_data_t data);
        logic [47:0] word;
        int          k;
        word = {addr, data};
        for (k = 0; k < previewer_pkg::CMD_BYTES; k++) begin
            @(negedge core_clk);
            cmd_valid = 1'b1;
            cmd_byte  = word[47 - 8 * k -: 8];
        end
        @(negedge core_clk);
        cmd_valid = 1'b0;
        // low half of the data word sets the corner
        if (addr == previewer_pkg::ADDR_ROI_COL) begin
            corner_col = data[15:0];
        end else if (addr == previewer_pkg::ADDR_ROI_ROW) begin
            corner_row = data[15:0];
        end
    endtask

    // random raw frame and the bytes the host should see for it
    task automatic build_frame();
        int i;
        int r;
        int c;
        exp_q.delete();
        for (i = 0; i < RAW_PIXELS; i++) begin
            raw_frame[i] = rand_below(256);
        end
        for (i = 0; i < previewer_pkg::MAGIC_BYTES; i++) begin
            exp_q.push_back(MAGIC_TEXT[63 - 8 * i -: 8]);
        end
        for (r = 0; r < ROI_HEIGHT; r++) begin
            for (c = 0; c < ROI_WIDTH; c++) begin
                exp_q.push_back(raw_frame[(corner_row + r) * RAW_WIDTH + corner_col + c]);
            end
        end
    endtask

    task automatic drive_frame();
        int i;
        int gap;
        for (i = 0; i < RAW_PIXELS; i++) begin
            gap = (rand_below(4) == 0) ? 1 + rand_below(3) : 0;
            repeat (gap) begin
                step();
                pix_valid = 1'b0;
                pix_sof   = 1'b0;
            end
            step();
            pix_valid = 1'b1;
            pix_sof   = (i == 0);
            pix_data  = raw_frame[i];
        end
        step();
        pix_valid = 1'b0;
        pix_sof   = 1'b0;
    endtask

    task automatic collect_check(string name);
        int waited;
        int i;
        waited = 0;
        while (got_q.size() < exp_q.size() && waited < WAIT_LIMIT) begin
            step();
            waited++;
        end
        if (got_q.size() < exp_q.size()) begin
            errors++;
            $display("test %s timed out waiting for the frame bytes", name);
        end
        // a few more cycles to catch stray bytes
        repeat (10) step();
        check_val({name, " byte count"}, FRAME_BYTES, got_q.size());
        for (i = 0; i < exp_q.size() && i < got_q.size(); i++) begin
            check_val($sformatf("%s byte %0d", name, i), exp_q[i], got_q[i]);
        end
        got_q.delete();
    endtask

    task automatic finish_test(string name, int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - errs_before);
        end
    endtask

    ////////////////////
    // test sequence

    initial begin
        int e0;
        int n;
        int new_col;
        int new_row;
        seed = 61;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        rand_ready = 1'b0;
        core_clk = 1'b0;
        sys_reset = 1'b1;
        cmd_byte = '0;
        cmd_valid = 1'b0;
        pix_data = '0;
        pix_valid = 1'b0;
        pix_sof = 1'b0;
        host_ready = 1'b1;
        corner_col = (RAW_WIDTH - ROI_WIDTH) / 2;
        corner_row = 0;
        repeat (4) @(negedge core_clk);
        sys_reset = 1'b0;

        // quiet output, then default centered crop
        e0 = errors;
        repeat (20) step();
        check_val("default_corner idle bytes", 0, got_q.size());
        build_frame();
        drive_frame();
        collect_check("default_corner");
        finish_test("default_corner", e0);

        e0 = errors;
        for (n = 0; n < 3; n++) begin
            send_cmd(previewer_pkg::ADDR_ROI_COL,
                     {16'(rand_below(65536)), 16'(rand_below(RAW_WIDTH - ROI_WIDTH + 1))});
            send_cmd(previewer_pkg::ADDR_ROI_ROW,
                     {16'(rand_below(65536)), 16'(rand_below(RAW_HEIGHT - ROI_HEIGHT + 1))});
            build_frame();
            drive_frame();
            collect_check("set_corner");
        end
        finish_test("set_corner", e0);

        e0 = errors;
        send_cmd(previewer_pkg::cmd_addr_t'(2 + rand_below(65534)),
                 previewer_pkg::cmd_data_t'($random(seed)));
        build_frame();
        drive_frame();
        collect_check("unused_addr");
        finish_test("unused_addr", e0);

        e0 = errors;
        rand_ready = 1'b1;
        for (n = 0; n < 2; n++) begin
            build_frame();
            drive_frame();
            collect_check("host_backpressure");
        end
        rand_ready = 1'b0;
        host_ready = 1'b1;
        finish_test("host_backpressure", e0);

        // corner written while the frame streams in, always a different one
        e0 = errors;
        new_col = (corner_col + 1 + rand_below(RAW_WIDTH - ROI_WIDTH))
                  % (RAW_WIDTH - ROI_WIDTH + 1);
        new_row = (corner_row + 1 + rand_below(RAW_HEIGHT - ROI_HEIGHT))
                  % (RAW_HEIGHT - ROI_HEIGHT + 1);
        build_frame();
        fork
            drive_frame();
            begin
                repeat (40) @(negedge core_clk);
                send_cmd(previewer_pkg::ADDR_ROI_COL, previewer_pkg::cmd_data_t'(new_col));
                send_cmd(previewer_pkg::ADDR_ROI_ROW, previewer_pkg::cmd_data_t'(new_row));
            end
        join
        collect_check("mid_frame_corner");
        build_frame();
        drive_frame();
        collect_check("mid_frame_corner next");
        finish_test("mid_frame_corner", e0);

        $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
hw/previewer_pkg.sv
hw/command_assembler.sv
hw/roi_cropper.sv
hw/frame_fifo.sv
hw/frame_sequencer.sv
hw/previewer_top.sv
dv/previewer_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the previewer testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal -f sources.f --top-module previewer_tb \
    -Mdir obj_dir -o previewer_sim \
    && ./obj_dir/previewer_sim > sim.log 2>&1 \
    || echo "build or simulation run did not complete"

grep -q "All tests passed" sim.log 2>/dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }
